/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - files:
      - hw/mem_pkg.sv
      - hw/fetch_pkg.sv
      - hw/fetch_ctrl.sv
      - hw/line_buffer.sv
      - hw/burst_deserializer.sv
      - hw/instr_queue.sv
      - hw/fetch_frontend.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/bmem_model.sv
      - bench/tb_fetch_frontend.sv

/* bench/mem_word.svh */
// backing memory contents, one word for every 32-bit address
// address mixed with a constant, then rotated left by its word index in the line
function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] mixed;
    logic [2:0]  rot;
    mixed = addr ^ 32'h5a5a_0000;
    rot   = addr[4:2];
    return (mixed << rot) | (mixed >> (6'd32 - rot));
endfunction

/* bench/bmem_model.sv */
`timescale 1ns/1ns

module bmem_model (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [mem_pkg::ADDR_W-1:0] addr_i,
    input  logic                       read_i,
    input  logic                       ready_en_i,
    input  logic                       beat_en_i,
    output logic                       ready_o,
    output mem_pkg::beat_t             rdata_o,
    output logic                       rvalid_o
);

    `include "mem_word.svh"

    logic                       busy = 1'b0;
    logic [mem_pkg::ADDR_W-1:0] base;
    int                         beat_idx;

    // no new request while a burst is still going out
    assign ready_o = !busy && ready_en_i;

    initial begin
        rdata_o  = '0;
        rvalid_o = 1'b0;
        base     = '0;
        beat_idx = 0;
    end

    always @(posedge clk) begin : serve_burst
        logic                       rst_s;
        logic                       take;
        logic                       go;
        logic [mem_pkg::ADDR_W-1:0] addr_s;
        // everything sampled at the edge, outputs change a little later
        rst_s  = rst;
        take   = read_i && ready_o;
        go     = beat_en_i;
        addr_s = addr_i;
        #1;
        rvalid_o = 1'b0;
        if (rst_s) begin
            busy     = 1'b0;
            beat_idx = 0;
        end else if (take) begin
            busy     = 1'b1;
            base     = addr_s;
            beat_idx = 0;
        end else if (busy && go) begin
            // lower word at the lower address
            rdata_o  = {mem_word(base + 8 * beat_idx + 4), mem_word(base + 8 * beat_idx)};
            rvalid_o = 1'b1;
            if (beat_idx == mem_pkg::BEATS_PER_LINE - 1) begin
                busy = 1'b0;
            end
            beat_idx = beat_idx + 1;
        end
    end

endmodule

/* bench/tb_fetch_frontend.sv */
`timescale 1ns/1ns

module tb_fetch_frontend;

    `include "mem_word.svh"

    localparam int RESET_CYCLES   = 10;
    localparam int NUM_POPS       = 200;
    localparam int TIMEOUT_CYCLES = 5000;
    // consumer stays idle in this window so the queue fills up
    localparam int STALL_START    = 120;
    localparam int STALL_END      = 320;

    logic                       clk;
    logic                       rst;
    logic [mem_pkg::ADDR_W-1:0] bmem_addr;
    logic                       bmem_read;
    logic                       bmem_ready;
    mem_pkg::beat_t             bmem_rdata;
    logic                       bmem_rvalid;
    logic                       ready_en;
    logic                       beat_en;
    logic                       deq;
    fetch_pkg::fetch_pkt_t      pkt;
    logic                       empty;

    integer                          seed = 32'hdb34_199f;
    int                              cycle_cnt = 0;
    int                              pop_count = 0;
    int                              reads_issued = 0;
    int                              value_errors = 0;
    int                              protocol_errors = 0;
    int                              timeout_errors = 0;
    logic [mem_pkg::ADDR_W-1:0]      model_pc = fetch_pkg::PC_RESET;
    logic [fetch_pkg::ORDER_W-1:0]   model_order = '0;
    logic [mem_pkg::ADDR_W-1:0]      exp_line_addr = {fetch_pkg::PC_RESET[31:5], 5'b0};

    fetch_frontend dut (
        .clk           (clk),
        .rst           (rst),
        .bmem_addr_o   (bmem_addr),
        .bmem_read_o   (bmem_read),
        .bmem_ready_i  (bmem_ready),
        .bmem_rdata_i  (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid),
        .deq_i         (deq),
        .pkt_o         (pkt),
        .empty_o       (empty)
    );

    bmem_model u_mem (
        .clk        (clk),
        .rst        (rst),
        .addr_i     (bmem_addr),
        .read_i     (bmem_read),
        .ready_en_i (ready_en),
        .beat_en_i  (beat_en),
        .ready_o    (bmem_ready),
        .rdata_o    (bmem_rdata),
        .rvalid_o   (bmem_rvalid)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_value(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
        $display("ERROR %s at %0t: expected 0x%0h, actual 0x%0h", name, $time, exp, act);
        value_errors++;
    endtask

    task automatic check_read;
        if (bmem_ready !== 1'b1) begin
            $display("read request issued at %0t while memory was not ready", $time);
            protocol_errors++;
        end
        // one request per line, in address order
        if (bmem_addr !== exp_line_addr) begin
            report_value("read_addr", exp_line_addr, bmem_addr);
        end
        exp_line_addr = exp_line_addr + 32;
        reads_issued++;
    endtask

    task automatic check_pop;
        logic [31:0] exp_inst;
        exp_inst = mem_word(model_pc);
        if (pkt.pc !== model_pc) begin
            report_value("pop_pc", model_pc, pkt.pc);
        end
        if (pkt.order !== model_order) begin
            report_value("pop_order", model_order, pkt.order);
        end
        if (pkt.inst !== exp_inst) begin
            report_value("pop_inst", exp_inst, pkt.inst);
        end
        model_pc    = model_pc + fetch_pkg::PC_STEP;
        model_order = model_order + 1;
        pop_count++;
    endtask

    // inputs settle 1 ns after the edge, so the falling edge sees stable values
    always @(negedge clk) begin
        if (!rst) begin
            if (bmem_read) begin
                check_read();
            end
            if (deq && !empty) begin
                check_pop();
            end
        end
    end

    initial begin : drive_stimulus
        logic [31:0] r;
        deq      = 1'b0;
        ready_en = 1'b0;
        beat_en  = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            cycle_cnt++;
            r        = $random(seed);
            ready_en = (r[0] == 1'b1);
            r        = $random(seed);
            beat_en  = (r[2:0] > 3'd2);
            r        = $random(seed);
            if (cycle_cnt >= STALL_START && cycle_cnt < STALL_END) begin
                deq = 1'b0;
            end else begin
                deq = (r[1:0] != 2'b00);
            end
        end
    end

    initial begin : run_test
        int wait_cycles;
        int lines_used;
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        @(negedge clk);
        if (empty !== 1'b1) begin
            $display("empty_o is not high right after reset");
            protocol_errors++;
        end
        if (bmem_read !== 1'b0) begin
            $display("bmem_read_o is not low right after reset");
            protocol_errors++;
        end

        wait_cycles = 0;
        while (pop_count < NUM_POPS && wait_cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (pop_count < NUM_POPS) begin
            $display("timed out after %0d cycles with %0d of %0d packets popped",
                     wait_cycles, pop_count, NUM_POPS);
            timeout_errors++;
        end

        // every consumed line must have been requested
        if (pop_count > 0) begin
            lines_used = ((model_pc - fetch_pkg::PC_STEP - {fetch_pkg::PC_RESET[31:5], 5'b0})
                          >> 5) + 1;
            if (reads_issued < lines_used) begin
                $display("only %0d read requests for %0d lines consumed",
                         reads_issued, lines_used);
                protocol_errors++;
            end
        end

        $display("pops %0d, reads %0d, value errors %0d, protocol errors %0d, timeouts %0d",
                 pop_count, reads_issued, value_errors, protocol_errors, timeout_errors);
        if (value_errors + protocol_errors + timeout_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* fetch_frontend.f */
+incdir+bench
hw/mem_pkg.sv
hw/fetch_pkg.sv
hw/fetch_ctrl.sv
hw/line_buffer.sv
hw/burst_deserializer.sv
hw/instr_queue.sv
hw/fetch_frontend.sv
bench/bmem_model.sv
bench/tb_fetch_frontend.sv

/* hw/burst_deserializer.sv */
`timescale 1ns/1ns

module burst_deserializer (
    input  logic           clk,
    input  logic           rst,
    input  mem_pkg::beat_t bmem_rdata_i,
    input  logic           bmem_rvalid_i,
    output mem_pkg::line_t line_o,
    output logic           line_valid_o
);

    logic [$clog2(mem_pkg::BEATS_PER_LINE)-1:0] beat_cnt;
    logic                                       last_beat;

    // beats arrive lowest address first
    assign last_beat = bmem_rvalid_i &&
                       (beat_cnt == mem_pkg::BEATS_PER_LINE - 1);

    // counter wraps on the last beat of a line
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (bmem_rvalid_i) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // each beat goes into its own slot
    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            line_o[beat_cnt*mem_pkg::BEAT_W +: mem_pkg::BEAT_W] <= bmem_rdata_i;
        end
    end

    // pulse in the cycle after the last beat, line_o is complete then
    always_ff @(posedge clk) begin
        if (rst) begin
            line_valid_o <= 1'b0;
        end else begin
            line_valid_o <= last_beat;
        end
    end

endmodule

/* hw/fetch_ctrl.sv */
`timescale 1ns/1ns

module fetch_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         hit_i,
    input  logic [fetch_pkg::INST_W-1:0] inst_i,
    input  logic                         full_i,
    input  logic                         line_valid_i,
    output logic [mem_pkg::ADDR_W-1:0]   pc_o,
    output logic                         enq_o,
    output fetch_pkg::fetch_pkt_t        pkt_o,
    output logic                         bmem_read_o,
    output logic [mem_pkg::ADDR_W-1:0]   bmem_addr_o,
    input  logic                         bmem_ready_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT
    } miss_state_t;

    miss_state_t                   state;
    miss_state_t                   state_next;
    logic [mem_pkg::ADDR_W-1:0]    pc;
    logic [fetch_pkg::ORDER_W-1:0] order;
    logic                          fire;

    // one packet per cycle while the line buffer covers pc and the queue has room
    assign fire = (state == ST_IDLE) && hit_i && !full_i;

    assign pc_o = pc;

    // queue takes the packet on the same edge that steps pc and order
    assign enq_o = fire;

    // pc stays put during a miss, so the request address is stable too
    assign bmem_addr_o = {pc[mem_pkg::ADDR_W-1:mem_pkg::LINE_OFFSET_W],
                          {mem_pkg::LINE_OFFSET_W{1'b0}}};

    // single cycle request, only while memory accepts
    assign bmem_read_o = (state == ST_REQ) && bmem_ready_i;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (!hit_i) begin
                    state_next = ST_REQ;
                end
            end
            ST_REQ: begin
                if (bmem_ready_i) begin
                    state_next = ST_WAIT;
                end
            end
            ST_WAIT: begin
                // line buffer loads on this pulse and hits next cycle
                if (line_valid_i) begin
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            pc    <= fetch_pkg::PC_RESET;
            order <= '0;
        end else begin
            state <= state_next;
            if (fire) begin
                pc    <= pc + fetch_pkg::PC_STEP;
                order <= order + 1'b1;
            end
        end
    end

    // packet payload, only meaningful when enq_o is high
    always_comb begin
        pkt_o.order = order;
        pkt_o.pc    = pc;
        pkt_o.inst  = inst_i;
    end

endmodule

/* hw/fetch_frontend.sv */
`timescale 1ns/1ns

module fetch_frontend (
    input  logic                       clk,
    input  logic                       rst,

    // backing memory
    output logic [mem_pkg::ADDR_W-1:0] bmem_addr_o,
    output logic                       bmem_read_o,
    input  logic                       bmem_ready_i,
    input  mem_pkg::beat_t             bmem_rdata_i,
    input  logic                       bmem_rvalid_i,

    // decoder
    input  logic                       deq_i,
    output fetch_pkg::fetch_pkt_t      pkt_o,
    output logic                       empty_o
);

    logic [mem_pkg::ADDR_W-1:0]   pc;
    logic                         hit;
    logic [fetch_pkg::INST_W-1:0] inst;
    mem_pkg::line_t               line;
    logic                         line_valid;
    logic                         enq;
    fetch_pkg::fetch_pkt_t        enq_pkt;
    logic                         full;

    fetch_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .hit_i        (hit),
        .inst_i       (inst),
        .full_i       (full),
        .line_valid_i (line_valid),
        .pc_o         (pc),
        .enq_o        (enq),
        .pkt_o        (enq_pkt),
        .bmem_read_o  (bmem_read_o),
        .bmem_addr_o  (bmem_addr_o),
        .bmem_ready_i (bmem_ready_i)
    );

    line_buffer u_line_buffer (
        .clk          (clk),
        .rst          (rst),
        .pc_i         (pc),
        .line_i       (line),
        .line_valid_i (line_valid),
        .hit_o        (hit),
        .inst_o       (inst)
    );

    burst_deserializer u_deser (
        .clk           (clk),
        .rst           (rst),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i),
        .line_o        (line),
        .line_valid_o  (line_valid)
    );

    instr_queue u_queue (
        .clk     (clk),
        .rst     (rst),
        .enq_i   (enq),
        .pkt_i   (enq_pkt),
        .deq_i   (deq_i),
        .pkt_o   (pkt_o),
        .full_o  (full),
        .empty_o (empty_o)
    );

endmodule

/* hw/fetch_pkg.sv */
package fetch_pkg;

    // instruction word and order counter
    localparam int INST_W  = 32;
    localparam int ORDER_W = 64;

    // program counter start and step
    localparam logic [mem_pkg::ADDR_W-1:0] PC_RESET = 32'haaaaa000;
    localparam logic [mem_pkg::ADDR_W-1:0] PC_STEP  = 32'd4;

    // instruction queue sizing
    localparam int IQ_DEPTH = 16;
    localparam int IQ_PTR_W = $clog2(IQ_DEPTH);
    // one extra bit so a full queue is distinct from an empty one
    localparam int IQ_CNT_W = IQ_PTR_W + 1;

    // packet handed to the decoder, order in the top bits
    typedef struct packed {
        logic [ORDER_W-1:0]         order;
        logic [mem_pkg::ADDR_W-1:0] pc;
        logic [INST_W-1:0]          inst;
    } fetch_pkt_t;

endpackage

/* hw/instr_queue.sv */
`timescale 1ns/1ns

module instr_queue (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enq_i,
    input  fetch_pkg::fetch_pkt_t pkt_i,
    input  logic                  deq_i,
    output fetch_pkg::fetch_pkt_t pkt_o,
    output logic                  full_o,
    output logic                  empty_o
);

    fetch_pkg::fetch_pkt_t mem [fetch_pkg::IQ_DEPTH];

    logic [fetch_pkg::IQ_PTR_W-1:0] wr_ptr;
    logic [fetch_pkg::IQ_PTR_W-1:0] rd_ptr;
    logic [fetch_pkg::IQ_CNT_W-1:0] count;
    logic                           push;
    logic                           pop;

    // requests that cannot be served are dropped
    assign push = enq_i && !full_o;
    assign pop  = deq_i && !empty_o;

    assign full_o  = (count == fetch_pkg::IQ_DEPTH);
    assign empty_o = (count == '0);

    // head is always visible, only valid while not empty
    assign pkt_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= pkt_i;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hw/line_buffer.sv */
`timescale 1ns/1ns

module line_buffer (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [mem_pkg::ADDR_W-1:0]   pc_i,
    input  mem_pkg::line_t               line_i,
    input  logic                         line_valid_i,
    output logic                         hit_o,
    output logic [fetch_pkg::INST_W-1:0] inst_o
);

    mem_pkg::line_t    line_q;
    mem_pkg::line_tag_t tag_q;
    logic              valid_q;
    mem_pkg::line_tag_t pc_tag;
    logic [mem_pkg::LINE_OFFSET_W-3:0] word_idx;

    assign pc_tag   = pc_i[mem_pkg::ADDR_W-1:mem_pkg::LINE_OFFSET_W];
    // word select, byte bits dropped
    assign word_idx = pc_i[mem_pkg::LINE_OFFSET_W-1:2];

    // only the valid bit matters after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (line_valid_i) begin
            valid_q <= 1'b1;
        end
    end

    // pc is held during a miss, so its tag names the arriving line
    always_ff @(posedge clk) begin
        if (line_valid_i) begin
            line_q <= line_i;
            tag_q  <= pc_tag;
        end
    end

    assign hit_o  = valid_q && (tag_q == pc_tag);
    assign inst_o = line_q[word_idx*fetch_pkg::INST_W +: fetch_pkg::INST_W];

endmodule

/* hw/mem_pkg.sv */
package mem_pkg;

    // backing memory bus
    localparam int ADDR_W = 32;
    localparam int BEAT_W = 64;

    // cache line geometry
    localparam int LINE_W         = 256;
    localparam int BEATS_PER_LINE = LINE_W / BEAT_W;
    localparam int LINE_OFFSET_W  = 5;

    // one beat as it arrives from memory
    typedef logic [BEAT_W-1:0] beat_t;

    // full line, lowest address in the low bits
    typedef logic [LINE_W-1:0] line_t;

    // address bits above the byte offset inside a line
    typedef logic [ADDR_W-LINE_OFFSET_W-1:0] line_tag_t;

endpackage
